//--- verilog/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// datapath widths shared by the ALU, the register file and the top level
// a word is the native register and bus width of the core
`define WORD 32

// half-word and byte widths drive the extension and byte reversal operations
`define HALF_WORD 16
`define BYTE 8

// number of architectural registers visible to an instruction
// the register index type in exec_pkg is sized from this value
`define REG_COUNT 16

`endif

//--- verilog/alu_pkg.sv
package alu_pkg;

    // ALU operation select, carried from the issue port straight into the ALU
    // the shift group only looks at the low byte of the second operand
    // the extension and reversal groups work on the first operand alone
    typedef enum logic [4:0] {
        // shifts and rotation
        ALU_LSL   = 5'd0,
        ALU_LSR   = 5'd1,
        ALU_ASR   = 5'd2,
        ALU_ROR   = 5'd3,
        // arithmetic, the first four also produce carry out
        ALU_ADD   = 5'd4,
        ALU_SUB   = 5'd5,
        ALU_ADC   = 5'd6,
        ALU_SBC   = 5'd7,
        // multiply keeps only the low word of the product
        ALU_MUL   = 5'd8,
        // bitwise logic
        ALU_AND   = 5'd9,
        ALU_ORR   = 5'd10,
        ALU_EOR   = 5'd11,
        ALU_NOT   = 5'd12,
        ALU_BIC   = 5'd13,
        // sign and zero extension of the low half-word or byte
        ALU_SXTH  = 5'd14,
        ALU_SXTB  = 5'd15,
        ALU_UXTH  = 5'd16,
        ALU_UXTB  = 5'd17,
        // byte reversals
        // REV swaps all four bytes, REV16 swaps inside each half-word
        // REVSH swaps the low half-word and sign extends it
        ALU_REV   = 5'd18,
        ALU_REV16 = 5'd19,
        ALU_REVSH = 5'd20
    } alu_op_e;

endpackage

//--- verilog/exec_pkg.sv
`include "core_settings.svh"

package exec_pkg;

    // condition codes in the usual ARM encoding order
    // each one is tested against the stored N, Z, C and V flags
    typedef enum logic [3:0] {
        COND_EQ = 4'h0,
        COND_NE = 4'h1,
        COND_CS = 4'h2,
        COND_CC = 4'h3,
        COND_MI = 4'h4,
        COND_PL = 4'h5,
        COND_VS = 4'h6,
        COND_VC = 4'h7,
        // unsigned higher and lower-or-same use carry together with zero
        COND_HI = 4'h8,
        COND_LS = 4'h9,
        // the signed comparisons compare N against V
        COND_GE = 4'ha,
        COND_LT = 4'hb,
        COND_GT = 4'hc,
        COND_LE = 4'hd,
        COND_AL = 4'he,
        // NV never passes, so an instruction with it is always skipped
        COND_NV = 4'hf
    } cond_e;

    // index into the architectural register file
    // wide enough to address every register and nothing more
    typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;

endpackage

//--- verilog/alu.sv
`include "core_settings.svh"

module alu
    import alu_pkg::*;
(
    input  alu_op_e          op_i,
    input  logic             carry_i,
    input  logic [`WORD-1:0] a_i,
    input  logic [`WORD-1:0] b_i,

    output logic [`WORD-1:0] result_o,
    output logic             n_o,
    output logic             z_o,
    output logic             c_o,
    output logic             v_o
);

    // rotation only needs enough bits to cover one word
    localparam int ROT_W = $clog2(`WORD);

    // one extra bit above the word holds the carry out of the adder
    logic [`WORD:0]     ext_sum;
    // second adder operand, inverted for the two subtract operations
    logic [`WORD-1:0]   b_eff;
    // carry into the adder, one for plain subtract to finish the negation
    logic               adder_cin;
    logic [`BYTE-1:0]   shamt;
    logic [ROT_W-1:0]   rot;
    logic               is_sub;
    logic               is_arith;
    logic               ovf;

    // every shift takes its amount from the low byte of the second operand
    assign shamt = b_i[`BYTE-1:0];

    // rotating by a whole word gives the input back, so the amount wraps
    assign rot = shamt[ROT_W-1:0];

    assign is_sub   = (op_i == ALU_SUB) || (op_i == ALU_SBC);
    assign is_arith = (op_i == ALU_ADD) || (op_i == ALU_SUB) ||
                      (op_i == ALU_ADC) || (op_i == ALU_SBC);

    // a single 33-bit adder serves add, subtract and both carry variants
    // subtract is a + ~b + 1 and subtract with carry is a + ~b + c,
    // which equals a - b - !c
    always_comb begin
        b_eff = is_sub ? ~b_i : b_i;
        case (op_i)
            ALU_SUB: adder_cin = 1'b1;
            ALU_ADC: adder_cin = carry_i;
            ALU_SBC: adder_cin = carry_i;
            default: adder_cin = 1'b0;
        endcase
        ext_sum = {1'b0, a_i} + {1'b0, b_eff} + {{`WORD{1'b0}}, adder_cin};
    end

    always_comb begin
        result_o = '0;
        case (op_i)
            ALU_LSL: result_o = a_i << shamt;
            ALU_LSR: result_o = a_i >> shamt;
            ALU_ASR: result_o = $signed(a_i) >>> shamt;
            // a zero rotate shifts the left half out by a full word and leaves a_i
            ALU_ROR: result_o = (a_i >> rot) | (a_i << (`WORD - rot));
            ALU_ADD: result_o = ext_sum[`WORD-1:0];
            ALU_SUB: result_o = ext_sum[`WORD-1:0];
            ALU_ADC: result_o = ext_sum[`WORD-1:0];
            ALU_SBC: result_o = ext_sum[`WORD-1:0];
            // the product is truncated to its low word
            ALU_MUL: result_o = a_i * b_i;
            ALU_AND: result_o = a_i & b_i;
            ALU_ORR: result_o = a_i | b_i;
            ALU_EOR: result_o = a_i ^ b_i;
            ALU_NOT: result_o = ~a_i;
            ALU_BIC: result_o = a_i & ~b_i;
            ALU_SXTH: begin
                result_o = {{(`WORD-`HALF_WORD){a_i[`HALF_WORD-1]}},
                            a_i[`HALF_WORD-1:0]};
            end
            ALU_SXTB: begin
                result_o = {{(`WORD-`BYTE){a_i[`BYTE-1]}}, a_i[`BYTE-1:0]};
            end
            ALU_UXTH: result_o = {{(`WORD-`HALF_WORD){1'b0}}, a_i[`HALF_WORD-1:0]};
            ALU_UXTB: result_o = {{(`WORD-`BYTE){1'b0}}, a_i[`BYTE-1:0]};
            // full reversal puts byte zero on top
            ALU_REV: begin
                result_o = {a_i[`BYTE-1:0], a_i[2*`BYTE-1 -: `BYTE],
                            a_i[3*`BYTE-1 -: `BYTE], a_i[4*`BYTE-1 -: `BYTE]};
            end
            // each half-word keeps its place but has its two bytes swapped
            ALU_REV16: begin
                result_o = {a_i[3*`BYTE-1 -: `BYTE], a_i[4*`BYTE-1 -: `BYTE],
                            a_i[`BYTE-1:0], a_i[2*`BYTE-1 -: `BYTE]};
            end
            // swapped low half-word, sign taken from the byte that lands on top
            ALU_REVSH: begin
                result_o = {{(`WORD-`HALF_WORD){a_i[`BYTE-1]}},
                            a_i[`BYTE-1:0], a_i[2*`BYTE-1 -: `BYTE]};
            end
            default: result_o = '0;
        endcase
    end

    // signed overflow happens when both adder operands share a sign
    // and the sum comes out with the opposite sign
    assign ovf = (a_i[`WORD-1] == b_eff[`WORD-1]) &&
                 (ext_sum[`WORD-1] != a_i[`WORD-1]);

    assign n_o = result_o[`WORD-1];
    assign z_o = (result_o == '0);

    // carry is only meaningful for the four adder operations
    assign c_o = is_arith ? ext_sum[`WORD] : 1'b0;

    // overflow is reported for plain add and subtract only
    // the carry variants leave V clear
    assign v_o = ((op_i == ALU_ADD) || (op_i == ALU_SUB)) ? ovf : 1'b0;

    // no operation outside add and subtract may raise the overflow flag
    always_comb begin
        v_only_add_sub: assert final (!v_o || op_i == ALU_ADD || op_i == ALU_SUB)
            else $error("alu: V set for operation %s", op_i.name());
    end

endmodule

//--- verilog/flag_unit.sv
module flag_unit
    import exec_pkg::*;
(
    input  logic  clk_i,
    input  logic  reset_i,
    input  cond_e cond_i,
    input  logic  update_i,
    input  logic  n_i,
    input  logic  z_i,
    input  logic  c_i,
    input  logic  v_i,

    output logic  n_o,
    output logic  z_o,
    output logic  c_o,
    output logic  v_o,
    output logic  cond_pass_o
);

    // stored status flags, loaded only when the top level asks for it
    // update_i already combines issue, set-flags and a passing condition
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            n_o <= 1'b0;
            z_o <= 1'b0;
            c_o <= 1'b0;
            v_o <= 1'b0;
        end else if (update_i) begin
            n_o <= n_i;
            z_o <= z_i;
            c_o <= c_i;
            v_o <= v_i;
        end
    end

    // the condition is tested against the flags as they stand in the issue cycle
    // so a flag-setting instruction cannot influence its own condition
    always_comb begin
        cond_pass_o = 1'b0;
        case (cond_i)
            COND_EQ: cond_pass_o = z_o;
            COND_NE: cond_pass_o = !z_o;
            COND_CS: cond_pass_o = c_o;
            COND_CC: cond_pass_o = !c_o;
            COND_MI: cond_pass_o = n_o;
            COND_PL: cond_pass_o = !n_o;
            COND_VS: cond_pass_o = v_o;
            COND_VC: cond_pass_o = !v_o;
            COND_HI: cond_pass_o = c_o && !z_o;
            COND_LS: cond_pass_o = !c_o || z_o;
            COND_GE: cond_pass_o = (n_o == v_o);
            COND_LT: cond_pass_o = (n_o != v_o);
            COND_GT: cond_pass_o = !z_o && (n_o == v_o);
            COND_LE: cond_pass_o = z_o || (n_o != v_o);
            COND_AL: cond_pass_o = 1'b1;
            COND_NV: cond_pass_o = 1'b0;
        endcase
    end

    // outside reset the flags hold their value across any edge without an update
    flags_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        !update_i |=> $stable({n_o, z_o, c_o, v_o}))
        else $error("flag_unit: flags changed without update");

endmodule

//--- verilog/register_file.sv
`include "core_settings.svh"

module register_file
    import exec_pkg::*;
(
    input  logic             clk_i,
    input  logic             reset_i,
    input  reg_idx_t         rd_idx_a_i,
    input  reg_idx_t         rd_idx_b_i,
    input  logic             wr_en_i,
    input  reg_idx_t         wr_idx_i,
    input  logic [`WORD-1:0] wr_data_i,

    output logic [`WORD-1:0] rd_data_a_o,
    output logic [`WORD-1:0] rd_data_b_o
);

    // architectural registers, all cleared to zero by reset
    logic [`WORD-1:0] regs [`REG_COUNT];

    // a single write port, so the top level resolves load against issue
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i) begin
            regs[wr_idx_i] <= wr_data_i;
        end
    end

    // reads are combinational and return the contents after the last edge
    // a write at one edge is therefore visible to the very next instruction
    assign rd_data_a_o = regs[rd_idx_a_i];
    assign rd_data_b_o = regs[rd_idx_b_i];

    // a write must target an existing register, which matters if the index
    // type ever grows wider than the register count
    wr_idx_range: assert property (@(posedge clk_i) disable iff (reset_i)
        wr_en_i |-> (int'(wr_idx_i) < `REG_COUNT))
        else $error("register_file: write index %0d out of range", wr_idx_i);

endmodule

//--- verilog/exec_unit.sv
`include "core_settings.svh"

module exec_unit
    import alu_pkg::*;
    import exec_pkg::*;
(
    input  logic             clk_i,
    input  logic             reset_i,
    // instruction issue, valid for one cycle when issue_i is high
    input  logic             issue_i,
    input  alu_op_e          op_i,
    input  cond_e            cond_i,
    input  logic             set_flags_i,
    input  reg_idx_t         rd_i,
    input  reg_idx_t         rn_i,
    input  reg_idx_t         rm_i,
    // direct register load from outside the core
    input  logic             load_i,
    input  reg_idx_t         load_idx_i,
    input  logic [`WORD-1:0] load_data_i,

    output logic [`WORD-1:0] result_o,
    output logic             executed_o,
    output logic             skipped_o,
    output logic             flag_n_o,
    output logic             flag_z_o,
    output logic             flag_c_o,
    output logic             flag_v_o
);

    logic [`WORD-1:0] rn_data;
    logic [`WORD-1:0] rm_data;
    logic [`WORD-1:0] alu_result;
    logic             alu_n;
    logic             alu_z;
    logic             alu_c;
    logic             alu_v;
    logic             cond_pass;
    logic             exec_now;
    logic             wr_en;
    reg_idx_t         wr_idx;
    logic [`WORD-1:0] wr_data;

    // an issued instruction takes effect only when its condition passes
    assign exec_now = issue_i && cond_pass;

    // load wins the write port, while a colliding issue still touches the flags
    assign wr_en   = load_i || exec_now;
    assign wr_idx  = load_i ? load_idx_i : rd_i;
    assign wr_data = load_i ? load_data_i : alu_result;

    register_file register_file_i (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .rd_idx_a_i  (rn_i),
        .rd_idx_b_i  (rm_i),
        .wr_en_i     (wr_en),
        .wr_idx_i    (wr_idx),
        .wr_data_i   (wr_data),
        .rd_data_a_o (rn_data),
        .rd_data_b_o (rm_data)
    );

    // the stored C flag feeds the carry variants of add and subtract
    alu alu_i (
        .op_i     (op_i),
        .carry_i  (flag_c_o),
        .a_i      (rn_data),
        .b_i      (rm_data),
        .result_o (alu_result),
        .n_o      (alu_n),
        .z_o      (alu_z),
        .c_o      (alu_c),
        .v_o      (alu_v)
    );

    flag_unit flag_unit_i (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .cond_i      (cond_i),
        .update_i    (exec_now && set_flags_i),
        .n_i         (alu_n),
        .z_i         (alu_z),
        .c_i         (alu_c),
        .v_i         (alu_v),
        .n_o         (flag_n_o),
        .z_o         (flag_z_o),
        .c_o         (flag_c_o),
        .v_o         (flag_v_o),
        .cond_pass_o (cond_pass)
    );

    // one register stage reports the outcome on the same edge as the writes
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            executed_o <= 1'b0;
            skipped_o  <= 1'b0;
        end else begin
            executed_o <= exec_now;
            skipped_o  <= issue_i && !cond_pass;
        end
    end

    // result is only meaningful alongside executed_o, so it follows issue alone
    always_ff @(posedge clk_i) begin
        if (issue_i) begin
            result_o <= alu_result;
        end
    end

    // an instruction either executes or is skipped, never both
    outcome_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
        !(executed_o && skipped_o))
        else $error("exec_unit: executed and skipped high together");

endmodule

//--- verification/exec_unit_tb.sv
`include "core_settings.svh"

module exec_unit_tb
    import alu_pkg::*;
    import exec_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    // one issued instruction as the model predicts it and the cycle it falls due in
    typedef struct packed {
        int               check_cycle;
        logic             exec;
        logic             skip;
        logic [`WORD-1:0] result;
        logic [3:0]       flags;
    } expect_t;

    localparam int OP_PASSES  = 2;
    localparam int NUM_RANDOM = 64;
    localparam int NUM_PAIRS  = 6;
    // reset, readback, loads, op sweep, arithmetic pairs, conditions, chain,
    // random mix, final readback and a margin for the drain at the end
    localparam int TIMEOUT_CYCLES = 2 + 16 + 16 + OP_PASSES * 21 * 3 + NUM_PAIRS * 6 +
                                    8 + 4 * 16 * 2 + 10 + NUM_RANDOM + 16 + 100;

    // operand pairs around the signed and unsigned boundaries
    localparam logic [31:0] ARITH_A [NUM_PAIRS] = '{32'h7fffffff, 32'h80000000,
        32'h80000000, 32'h00000000, 32'h00000005, 32'hffffffff};
    localparam logic [31:0] ARITH_B [NUM_PAIRS] = '{32'h00000001, 32'h80000000,
        32'h00000001, 32'h00000001, 32'h00000005, 32'h00000001};
    // compares giving Z+C, N, C+V and C alone, so each condition both passes and fails
    localparam logic [31:0] STATE_A [4] = '{32'd5, 32'd1, 32'h80000000, 32'd3};
    localparam logic [31:0] STATE_B [4] = '{32'd5, 32'd2, 32'd1, 32'd1};

    logic             clk_i = 1'b0;
    logic             reset_i;
    logic             issue_i;
    alu_op_e          op_i;
    cond_e            cond_i;
    logic             set_flags_i;
    reg_idx_t         rd_i;
    reg_idx_t         rn_i;
    reg_idx_t         rm_i;
    logic             load_i;
    reg_idx_t         load_idx_i;
    logic [`WORD-1:0] load_data_i;
    logic [`WORD-1:0] result_o;
    logic             executed_o;
    logic             skipped_o;
    logic             flag_n_o;
    logic             flag_z_o;
    logic             flag_c_o;
    logic             flag_v_o;

    // model state with the flags packed as {n, z, c, v}
    logic [`WORD-1:0] m_regs [`REG_COUNT];
    logic [3:0]       m_flags;
    expect_t          exp_q [$];
    logic [31:0]      lfsr = 32'hf79c231b;
    int               cycle_count = 0;
    int               check_count = 0;
    int               error_count = 0;

    exec_unit exec_unit_i (.*);

    always #5 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
    end

    // taps at bits 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // every bit handed out costs one LFSR step
    task automatic rand_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val = {val[30:0], lfsr[0]};
        end
    endtask

    // result and flags straight from the operation rules and packed as {n, z, c, v, result}
    function automatic logic [35:0] ref_alu(input alu_op_e op, input logic cin,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        logic [32:0] wide;
        logic        c;
        logic        v;
        r = a;
        c = 1'b0;
        v = 1'b0;
        case (op)
            // shifts move one bit per step, so large amounts saturate by themselves
            ALU_LSL: for (int i = 0; i < int'(b[7:0]); i++) r = {r[30:0], 1'b0};
            ALU_LSR: for (int i = 0; i < int'(b[7:0]); i++) r = {1'b0, r[31:1]};
            ALU_ASR: for (int i = 0; i < int'(b[7:0]); i++) r = {r[31], r[31:1]};
            ALU_ROR: for (int i = 0; i < int'(b[4:0]); i++) r = {r[0], r[31:1]};
            ALU_ADD: begin
                wide = {1'b0, a} + {1'b0, b};
                r = wide[31:0];
                c = wide[32];
                v = (a[31] == b[31]) && (r[31] != a[31]);
            end
            ALU_SUB: begin
                r = a - b;
                c = (a >= b);
                v = (a[31] != b[31]) && (r[31] != a[31]);
            end
            ALU_ADC: begin
                wide = {1'b0, a} + {1'b0, b} + 33'(cin);
                r = wide[31:0];
                c = wide[32];
            end
            // a borrow clears carry, as with a plain subtract
            ALU_SBC: begin
                r = a - b - 32'(!cin);
                c = ({1'b0, a} >= {1'b0, b} + 33'(!cin));
            end
            ALU_MUL:   r = a * b;
            ALU_AND:   r = a & b;
            ALU_ORR:   r = a | b;
            ALU_EOR:   r = a ^ b;
            ALU_NOT:   r = ~a;
            ALU_BIC:   r = a & ~b;
            ALU_SXTH:  r = 32'($signed(a[15:0]));
            ALU_SXTB:  r = 32'($signed(a[7:0]));
            ALU_UXTH:  r = 32'(a[15:0]);
            ALU_UXTB:  r = 32'(a[7:0]);
            ALU_REV:   r = {a[7:0], a[15:8], a[23:16], a[31:24]};
            ALU_REV16: r = {a[23:16], a[31:24], a[7:0], a[15:8]};
            ALU_REVSH: r = 32'($signed({a[7:0], a[15:8]}));
            default:   r = '0;
        endcase
        return {r[31], (r == 32'd0), c, v, r};
    endfunction

    // the upper three bits pick a test and the low bit inverts it, so NV is AL inverted
    function automatic logic cond_holds(input cond_e cc, input logic [3:0] f);
        logic t;
        case (cc[3:1])
            3'd0:    t = f[2];
            3'd1:    t = f[1];
            3'd2:    t = f[3];
            3'd3:    t = f[0];
            3'd4:    t = f[1] && !f[2];
            3'd5:    t = (f[3] == f[0]);
            3'd6:    t = !f[2] && (f[3] == f[0]);
            default: t = 1'b1;
        endcase
        return cc[0] ? !t : t;
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
        check_count++;
        assert (act_v === exp_v)
        else begin
            error_count++;
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp_v, act_v);
        end
    endtask

    task automatic load_reg(input reg_idx_t idx, input logic [31:0] data);
        @(negedge clk_i);
        issue_i = 1'b0;
        load_i = 1'b1;
        load_idx_i = idx;
        load_data_i = data;
        m_regs[idx] = data;
    endtask

    // drives one instruction and queues what the model expects one cycle later
    task automatic issue_op(input alu_op_e op, input cond_e cc, input logic sf,
                            input reg_idx_t rd, input reg_idx_t rn, input reg_idx_t rm);
        logic [35:0] res;
        logic        pass;
        expect_t     e;
        @(negedge clk_i);
        load_i = 1'b0;
        issue_i = 1'b1;
        op_i = op;
        cond_i = cc;
        set_flags_i = sf;
        rd_i = rd;
        rn_i = rn;
        rm_i = rm;
        res = ref_alu(op, m_flags[1], m_regs[rn], m_regs[rm]);
        pass = cond_holds(cc, m_flags);
        if (pass) begin
            m_regs[rd] = res[31:0];
        end
        if (pass && sf) begin
            m_flags = res[35:32];
        end
        e.check_cycle = cycle_count + 1;
        e.exec = pass;
        e.skip = !pass;
        e.result = res[31:0];
        e.flags = m_flags;
        exp_q.push_back(e);
    endtask

    task automatic idle_cycle();
        @(negedge clk_i);
        issue_i = 1'b0;
        load_i = 1'b0;
    endtask

    // registered outputs are settled by the falling edge, half a cycle after they change
    always @(negedge clk_i) begin : compare_outputs
        expect_t due;
        if (!reset_i) begin
            if (exp_q.size() > 0 && exp_q[0].check_cycle == cycle_count) begin
                due = exp_q.pop_front();
                check_val("executed_o", 32'(due.exec), 32'(executed_o));
                check_val("skipped_o", 32'(due.skip), 32'(skipped_o));
                if (due.exec) begin
                    check_val("result_o", due.result, result_o);
                end
                check_val("flag_n_o", 32'(due.flags[3]), 32'(flag_n_o));
                check_val("flag_z_o", 32'(due.flags[2]), 32'(flag_z_o));
                check_val("flag_c_o", 32'(due.flags[1]), 32'(flag_c_o));
                check_val("flag_v_o", 32'(due.flags[0]), 32'(flag_v_o));
            end else begin
                // no instruction is due, so neither outcome may be reported
                check_val("executed_o", 32'd0, 32'(executed_o));
                check_val("skipped_o", 32'd0, 32'(skipped_o));
            end
        end
    end

    initial begin : watchdog
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
        end
        $display("timeout after %0d cycles with %0d results still pending",
                 cycle_count, exp_q.size());
        $display("Test failed");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] rnd;
        logic [31:0] val;
        reg_idx_t    rn;
        reg_idx_t    rm;
        alu_op_e     op;
        reset_i = 1'b1;
        issue_i = 1'b0;
        op_i = ALU_ADD;
        cond_i = COND_AL;
        set_flags_i = 1'b0;
        rd_i = '0;
        rn_i = '0;
        rm_i = '0;
        load_i = 1'b0;
        load_idx_i = '0;
        load_data_i = '0;
        m_flags = 4'b0000;
        for (int i = 0; i < `REG_COUNT; i++) begin
            m_regs[i] = '0;
        end
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;
        check_val("executed_o", 32'd0, 32'(executed_o));
        check_val("skipped_o", 32'd0, 32'(skipped_o));
        check_val("flags_nzcv", 32'd0, 32'({flag_n_o, flag_z_o, flag_c_o, flag_v_o}));
        // every register should come back as zero through an add with r0
        for (int i = 0; i < `REG_COUNT; i++) begin
            issue_op(ALU_ADD, COND_AL, 1'b0, 4'(i), 4'(i), 4'd0);
        end
        for (int i = 0; i < `REG_COUNT; i++) begin
            rand_bits(32, val);
            load_reg(4'(i), val);
        end
        // each operation runs on fresh operands and shifts get amounts below and above a word
        for (int k = 0; k < OP_PASSES * 21; k++) begin
            op = alu_op_e'(5'(k % 21));
            rand_bits(4, rnd);
            rn = rnd[3:0];
            rand_bits(4, rnd);
            rm = rnd[3:0];
            rand_bits(32, val);
            load_reg(rn, val);
            rand_bits((op <= ALU_ROR) ? 6 : 32, val);
            load_reg(rm, val);
            rand_bits(5, rnd);
            issue_op(op, COND_AL, rnd[4], rnd[3:0], rn, rm);
        end
        // carry variants pick up the carry left by the op before them
        for (int p = 0; p < NUM_PAIRS; p++) begin
            load_reg(4'd1, ARITH_A[p]);
            load_reg(4'd2, ARITH_B[p]);
            issue_op(ALU_ADD, COND_AL, 1'b1, 4'd3, 4'd1, 4'd2);
            issue_op(ALU_SBC, COND_AL, 1'b1, 4'd3, 4'd1, 4'd2);
            issue_op(ALU_SUB, COND_AL, 1'b1, 4'd3, 4'd1, 4'd2);
            issue_op(ALU_ADC, COND_AL, 1'b1, 4'd3, 4'd1, 4'd2);
        end
        for (int s = 0; s < 4; s++) begin
            load_reg(4'(2 * s + 1), STATE_A[s]);
            load_reg(4'(2 * s + 2), STATE_B[s]);
        end
        // a compare sets up the flags and a conditional add then accumulates into r10
        // so that a write by a skipped add shows up in the next executed result
        for (int s = 0; s < 4; s++) begin
            for (int c = 0; c < 16; c++) begin
                issue_op(ALU_SUB, COND_AL, 1'b1, 4'd9, 4'(2 * s + 1), 4'(2 * s + 2));
                issue_op(ALU_ADD, cond_e'(4'(c)), 1'b1, 4'd10, 4'd10, 4'(2 * s + 1));
            end
        end
        // in the dependent chain each add reads what the previous one wrote
        load_reg(4'd12, 32'd1);
        load_reg(4'd13, 32'd3);
        for (int i = 0; i < 8; i++) begin
            issue_op(ALU_ADD, COND_AL, 1'b0, 4'd12, 4'd12, 4'd13);
        end
        for (int k = 0; k < NUM_RANDOM; k++) begin
            rand_bits(2, rnd);
            if (rnd[1:0] == 2'd0) begin
                rand_bits(4, rnd);
                rand_bits(32, val);
                load_reg(rnd[3:0], val);
            end else begin
                rand_bits(5, rnd);
                op = alu_op_e'(5'(rnd % 21));
                rand_bits(17, rnd);
                issue_op(op, cond_e'(rnd[16:13]), rnd[12], rnd[11:8], rnd[7:4], rnd[3:0]);
            end
        end
        // skipped writes would show up here as stale register contents
        for (int i = 0; i < `REG_COUNT; i++) begin
            issue_op(ALU_ORR, COND_AL, 1'b0, 4'(i), 4'(i), 4'(i));
        end
        idle_cycle();
        while (exp_q.size() > 0) begin
            @(negedge clk_i);
        end
        idle_cycle();
        $display("checks %0d errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+verilog
verilog/alu_pkg.sv
verilog/exec_pkg.sv
verilog/alu.sv
verilog/flag_unit.sv
verilog/register_file.sv
verilog/exec_unit.sv
verification/exec_unit_tb.sv

//--- Makefile
TOP = exec_unit_tb
LOG = sim.log

.PHONY: sim clean

# build and run, then pass only if the log holds the pass message
sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f flist.f -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
